// ==== legv8Pkg.sv ====
package legv8Pkg;

	// Datapath and field widths
	localparam int dataWidth = 64;
	localparam int instrWidth = 32;
	localparam int regWidth = 5;
	localparam int flagWidth = 4;
	localparam int opWidth = 11;

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [instrWidth-1:0] instrWord;
	typedef logic [regWidth-1:0] regIdx;
	typedef logic [flagWidth-1:0] flagBits;
	typedef logic [opWidth-1:0] opField;

	// Flag positions, stored as {carry, zero, overflow, negative}
	localparam int flagC = 3;
	localparam int flagZ = 2;
	localparam int flagV = 1;
	localparam int flagN = 0;

	// BL writes the return address here
	localparam regIdx linkReg = 5'd30;

	// Opcode patterns, compared on the top bits of the instruction
	localparam logic [9:0] opAddi = 10'b1001000100;
	localparam opField opAdds = 11'b10101011000;
	localparam opField opSubs = 11'b11101011000;
	localparam opField opLdur = 11'b11111000010;
	localparam opField opStur = 11'b11111000000;
	localparam opField opBr = 11'b11010110000;
	localparam logic [5:0] opBl = 6'b100101;
	localparam logic [7:0] opCbz = 8'b10110100;
	localparam logic [7:0] opBcond = 8'b01010100;
	localparam logic [3:0] condLt = 4'b1011;

	typedef enum logic [2:0] {
		aluPassB = 3'b000,
		aluAdd = 3'b010,
		aluSub = 3'b011,
		aluNone = 3'b111
	} aluOp;

	typedef enum logic [3:0] {
		clsAddi, clsAdds, clsSubs, clsLdur, clsStur,
		clsBl, clsBr, clsCbz, clsBlt, clsIllegal
	} instrClass;

	typedef struct packed {
		logic valid;
		instrClass cls;
		aluOp op;
		dataWord operandA;
		dataWord operandB;
		regIdx dest;
		dataWord branchOffset; // signed, in words
		dataWord pc;
	} decodedBundle;

	typedef struct packed {
		logic valid;
		instrClass cls;
		dataWord result;
		flagBits aluFlags;
		regIdx dest;
		dataWord branchOffset;
		dataWord pc;
	} executedBundle;

	typedef struct packed {
		logic valid;
		logic writeEn;
		regIdx dest;
		dataWord data;
		logic branchTaken;
		dataWord branchTarget;
		flagBits flags;
		logic illegal;
	} resultBundle;

endpackage

// ==== aluControlUnit.sv ====
`timescale 1ns/1ps

module aluControlUnit (
	input legv8Pkg::opField opcode,
	input logic aluOn,
	input logic sign,
	output legv8Pkg::aluOp aluCntrl
);
	import legv8Pkg::*;

	// Opcode slices per instruction format
	logic [9:0] iOp;
	logic [7:0] cbOp;
	logic [5:0] bOp;

	assign iOp = opcode[10:1];
	assign cbOp = opcode[10:3];
	assign bOp = opcode[10:5];

	always_comb begin
		// ALU not needed
		if (!aluOn) begin
			aluCntrl = aluNone;
		end

		else begin
			// ADDI and ADDS
			if (iOp == opAddi || opcode == opAdds) begin
				aluCntrl = aluAdd;
			end

			// LDUR and STUR, offset sign picks add or subtract
			else if (opcode == opStur || opcode == opLdur) begin
				aluCntrl = aluOp'({2'b01, sign});
			end

			// SUBS
			else if (opcode == opSubs) begin
				aluCntrl = aluSub;
			end

			// BL computes the link value
			else if (bOp == opBl) begin
				aluCntrl = aluAdd;
			end

			// BR
			else if (opcode == opBr) begin
				aluCntrl = aluPassB;
			end

			// CBZ
			else if (cbOp == opCbz) begin
				aluCntrl = aluPassB;
			end

			// B.cond
			else if (cbOp == opBcond) begin
				aluCntrl = aluPassB;
			end

			// Unsupported encodings
			else begin
				aluCntrl = aluNone;
			end
		end
	end

endmodule

// ==== opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input legv8Pkg::instrWord instr,
	input legv8Pkg::dataWord regA,
	input legv8Pkg::dataWord regB,
	input legv8Pkg::dataWord pc,
	output legv8Pkg::decodedBundle dec
);
	import legv8Pkg::*;

	opField opcode;
	instrClass cls;
	aluOp op;
	logic aluOn;
	logic [8:0] ldOff;
	logic [8:0] offMag;
	decodedBundle decNext;

	assign opcode = instr[31:21];

	// D-type offset as sign and magnitude
	assign ldOff = instr[20:12];
	assign offMag = ldOff[8] ? (~ldOff + 9'd1) : ldOff;

	// Checked in the same order as the ALU control unit
	always_comb begin
		if (instr[31:22] == opAddi) begin
			cls = clsAddi;
		end else if (opcode == opAdds) begin
			cls = clsAdds;
		end else if (opcode == opStur) begin
			cls = clsStur;
		end else if (opcode == opLdur) begin
			cls = clsLdur;
		end else if (opcode == opSubs) begin
			cls = clsSubs;
		end else if (opcode[10:5] == opBl) begin
			cls = clsBl;
		end else if (opcode == opBr) begin
			cls = clsBr;
		end else if (opcode[10:3] == opCbz) begin
			cls = clsCbz;
		end else if (opcode[10:3] == opBcond && instr[3:0] == condLt) begin
			cls = clsBlt;
		end else begin
			cls = clsIllegal;
		end
	end

	assign aluOn = (cls != clsIllegal);

	aluControlUnit ctrl (
		.opcode(opcode),
		.aluOn(aluOn),
		.sign(ldOff[8]),
		.aluCntrl(op)
	);

	// Operand selection
	always_comb begin
		decNext = '0;
		decNext.valid = inValid;
		decNext.cls = cls;
		decNext.op = op;
		decNext.pc = pc;
		decNext.dest = instr[4:0];
		decNext.operandA = regA;
		case (cls)
			clsAddi: decNext.operandB = dataWord'(instr[21:10]);
			clsAdds, clsSubs: decNext.operandB = regB;
			clsLdur, clsStur: decNext.operandB = dataWord'(offMag);
			clsBl: begin
				decNext.operandA = pc;
				decNext.operandB = 64'd4;
				decNext.dest = linkReg;
				decNext.branchOffset = {{38{instr[25]}}, instr[25:0]};
			end
			clsBr: decNext.operandB = regA;
			clsCbz, clsBlt: begin
				decNext.operandB = regB;
				decNext.branchOffset = {{45{instr[23]}}, instr[23:5]};
			end
			default: decNext.operandA = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		dec <= decNext;
		if (!rstN) begin
			dec.valid <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		dec.valid |-> ((dec.op == aluNone) == (dec.cls == clsIllegal)))
		else $error("Decoded op and class disagree on illegal");

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute (
	input logic clk,
	input logic rstN,
	input legv8Pkg::decodedBundle dec,
	output legv8Pkg::executedBundle exe
);
	import legv8Pkg::*;

	logic isSub;
	dataWord opA;
	dataWord opB;
	dataWord sum;
	logic carryOut;
	logic addOvf;
	dataWord result;
	flagBits flags;
	executedBundle exeNext;

	assign isSub = (dec.op == aluSub);
	assign opA = dec.operandA;

	// Subtract as A + ~B + 1
	assign opB = isSub ? ~dec.operandB : dec.operandB;
	assign {carryOut, sum} = {1'b0, opA} + {1'b0, opB} + {64'd0, isSub};

	// Operands agree in sign, sum does not
	assign addOvf = (opA[63] == opB[63]) && (sum[63] != opA[63]);

	always_comb begin
		flags = '0;
		case (dec.op)
			aluAdd, aluSub: begin
				result = sum;
				flags[flagC] = carryOut;
				flags[flagV] = addOvf;
			end
			aluPassB: begin
				result = dec.operandB;
			end
			default: begin
				result = '0;
			end
		endcase
		flags[flagZ] = (result == '0);
		flags[flagN] = result[63];
	end

	always_comb begin
		exeNext.valid = dec.valid;
		exeNext.cls = dec.cls;
		exeNext.result = result;
		exeNext.aluFlags = flags;
		exeNext.dest = dec.dest;
		exeNext.branchOffset = dec.branchOffset;
		exeNext.pc = dec.pc;
	end

	always_ff @(posedge clk) begin
		exe <= exeNext;
		if (!rstN) begin
			exe.valid <= 1'b0;
		end
	end

	// Zero flag against the operands of the previous cycle
	assert property (@(posedge clk) disable iff (!rstN)
		exe.valid |-> (exe.aluFlags[flagZ] == $past(
			(dec.op == aluSub) ? (dec.operandA == dec.operandB) :
			(dec.op == aluAdd) ? (dec.operandA + dec.operandB == '0) :
			(dec.op == aluPassB) ? (dec.operandB == '0) : 1'b1)))
		else $error("Zero flag does not match result");

endmodule

// ==== branchResolve.sv ====
`timescale 1ns/1ps

module branchResolve (
	input logic clk,
	input logic rstN,
	input legv8Pkg::executedBundle exe,
	output legv8Pkg::resultBundle res
);
	import legv8Pkg::*;

	flagBits flagReg;
	flagBits flagsNext;
	logic setsFlags;
	logic lessThan;
	dataWord target;
	resultBundle resNext;

	// Only ADDS and SUBS touch the flag register
	assign setsFlags = exe.valid && (exe.cls == clsAdds || exe.cls == clsSubs);
	assign flagsNext = setsFlags ? exe.aluFlags : flagReg;

	// B.LT sees the flags left by older instructions
	assign lessThan = flagReg[flagN] != flagReg[flagV];

	// Word offset scaled to bytes
	assign target = exe.pc + {exe.branchOffset[61:0], 2'b00};

	always_comb begin
		resNext = '0;
		resNext.valid = exe.valid;
		resNext.flags = flagsNext;
		resNext.data = exe.result;
		case (exe.cls)
			clsAddi, clsAdds, clsSubs, clsLdur: begin
				resNext.writeEn = exe.valid;
			end
			clsBl: begin
				resNext.writeEn = exe.valid;
				resNext.branchTaken = exe.valid;
				resNext.branchTarget = target;
			end
			clsBr: begin
				resNext.branchTaken = exe.valid;
				resNext.branchTarget = exe.result;
			end
			clsCbz: begin
				resNext.branchTaken = exe.valid && exe.aluFlags[flagZ];
				resNext.branchTarget = target;
			end
			clsBlt: begin
				resNext.branchTaken = exe.valid && lessThan;
				resNext.branchTarget = target;
			end
			clsIllegal: begin
				resNext.illegal = exe.valid;
				resNext.data = '0;
			end
			default: begin
				// STUR reports only its address
				resNext.writeEn = 1'b0;
			end
		endcase
		resNext.dest = resNext.writeEn ? exe.dest : '0;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flagReg <= '0;
		end else begin
			flagReg <= flagsNext;
		end
	end

	always_ff @(posedge clk) begin
		res <= resNext;
		if (!rstN) begin
			res.valid <= 1'b0;
			res.writeEn <= 1'b0;
			res.branchTaken <= 1'b0;
			res.illegal <= 1'b0;
			res.flags <= '0;
		end
	end

	// Only a BL both links and branches, writing pc + 4 to the link register
	assert property (@(posedge clk) disable iff (!rstN)
		(res.branchTaken && res.writeEn) |-> ($past(exe.cls) == clsBl
			&& res.dest == linkReg && res.data == $past(exe.pc) + 64'd4))
		else $error("Branch with writeback from a non-BL instruction");

endmodule

// ==== legv8ExecCore.sv ====
`timescale 1ns/1ps

module legv8ExecCore (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input legv8Pkg::instrWord instr,
	input legv8Pkg::dataWord regA,
	input legv8Pkg::dataWord regB,
	input legv8Pkg::dataWord pc,
	output legv8Pkg::resultBundle res
);
	import legv8Pkg::*;

	// Stage to stage bundles
	decodedBundle dec;
	executedBundle exe;

	opcodeDecoder decode (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.instr(instr),
		.regA(regA),
		.regB(regB),
		.pc(pc),
		.dec(dec)
	);

	aluExecute execute (
		.clk(clk),
		.rstN(rstN),
		.dec(dec),
		.exe(exe)
	);

	// Flags, branches and writeback report
	branchResolve resolve (
		.clk(clk),
		.rstN(rstN),
		.exe(exe),
		.res(res)
	);

endmodule

// ==== tbRefModel.svh ====
// Expected result of one instruction, given its operands and the flags left by older ones
function automatic resultBundle refResult(input instrWord ins, input dataWord a,
		input dataWord b, input dataWord pcVal, input flagBits flagsIn);
	resultBundle r;
	logic [64:0] wide;
	dataWord condTarget;
	r = '0;
	r.valid = 1'b1;
	r.flags = flagsIn;
	condTarget = pcVal + {{43{ins[23]}}, ins[23:5], 2'b00};
	if (ins[31:22] == opAddi) begin
		r.data = a + dataWord'(ins[21:10]);
		r.writeEn = 1'b1;
		r.dest = ins[4:0];
	end else if (ins[31:21] == opAdds) begin
		// Sign-extended sum overflows when its top two bits differ
		wide = {a[63], a} + {b[63], b};
		r.data = a + b;
		r.writeEn = 1'b1;
		r.dest = ins[4:0];
		r.flags = {(r.data < a), (r.data == 0), (wide[64] != wide[63]), r.data[63]};
	end else if (ins[31:21] == opSubs) begin
		// Carry set means no borrow
		r.data = a - b;
		r.writeEn = 1'b1;
		r.dest = ins[4:0];
		r.flags = {(a >= b), (r.data == 0), ((a[63] != b[63]) && (r.data[63] != a[63])),
			r.data[63]};
	end else if (ins[31:21] == opLdur || ins[31:21] == opStur) begin
		r.data = a + {{55{ins[20]}}, ins[20:12]};
		r.writeEn = (ins[31:21] == opLdur);
		r.dest = r.writeEn ? ins[4:0] : 5'd0;
	end else if (ins[31:26] == opBl) begin
		r.data = pcVal + 64'd4;
		r.writeEn = 1'b1;
		r.dest = 5'd30;
		r.branchTaken = 1'b1;
		r.branchTarget = pcVal + {{36{ins[25]}}, ins[25:0], 2'b00};
	end else if (ins[31:21] == opBr) begin
		r.data = a;
		r.branchTaken = 1'b1;
		r.branchTarget = a;
	end else if (ins[31:24] == opCbz) begin
		r.data = b;
		r.branchTaken = (b == 0);
		r.branchTarget = condTarget;
	end else if (ins[31:24] == opBcond && ins[3:0] == condLt) begin
		// Less than when N and V disagree
		r.data = b;
		r.branchTaken = (flagsIn[0] != flagsIn[1]);
		r.branchTarget = condTarget;
	end else begin
		r.illegal = 1'b1;
	end
	return r;
endfunction

// ==== tbLegv8ExecCore.sv ====
`timescale 1ns/1ps

module tbLegv8ExecCore;
	import legv8Pkg::*;

	logic clk;
	logic rstN;
	logic inValid;
	instrWord instr;
	dataWord regA;
	dataWord regB;
	dataWord pc;
	resultBundle res;

	integer seed;
	int cycle;
	int mismatchErrors;
	int otherErrors;
	flagBits modelFlags;
	resultBundle expQ[$];
	int issueQ[$];

	`include "tbRefModel.svh"

	legv8ExecCore DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic dataWord randomWord();
		return {$random(seed), $random(seed)};
	endfunction

	// Instruction encoders per format
	function automatic instrWord rType(input opField op, input regIdx rm, input regIdx rn,
			input regIdx rd);
		return {op, rm, 6'd0, rn, rd};
	endfunction

	function automatic instrWord iType(input logic [11:0] imm, input regIdx rn, input regIdx rd);
		return {opAddi, imm, rn, rd};
	endfunction

	function automatic instrWord dType(input opField op, input logic [8:0] off, input regIdx rn,
			input regIdx rt);
		return {op, off, 2'b00, rn, rt};
	endfunction

	function automatic instrWord blType(input logic [25:0] off);
		return {opBl, off};
	endfunction

	function automatic instrWord cbzType(input logic [18:0] off, input regIdx rt);
		return {opCbz, off, rt};
	endfunction

	function automatic instrWord bltType(input logic [18:0] off);
		return {opBcond, off, 1'b0, condLt};
	endfunction

	task automatic checkField(input string name, input logic [63:0] got,
			input logic [63:0] want);
		assert (got === want) else begin
			mismatchErrors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// Computes the expected result in program order, then drives the DUT
	task automatic issue(input instrWord ins, input dataWord a, input dataWord b,
			input dataWord p);
		resultBundle expRes;
		@(posedge clk);
		#5;
		expRes = refResult(ins, a, b, p, modelFlags);
		modelFlags = expRes.flags;
		expQ.push_back(expRes);
		issueQ.push_back(cycle);
		inValid = 1'b1;
		instr = ins;
		regA = a;
		regB = b;
		pc = p;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
			inValid = 1'b0;
		end
	endtask

	// Compare every valid result with the oldest expected one
	initial begin
		resultBundle expRes;
		int issued;
		forever begin
			@(negedge clk);
			if (rstN === 1'b1 && res.valid === 1'b1) begin
				if (expQ.size() == 0) begin
					otherErrors++;
					$display("Result at %0t arrived with nothing issued", $time);
				end else begin
					expRes = expQ.pop_front();
					issued = issueQ.pop_front();
					checkField("latency", cycle - issued, 3);
					checkField("res.writeEn", res.writeEn, expRes.writeEn);
					checkField("res.dest", res.dest, expRes.dest);
					checkField("res.data", res.data, expRes.data);
					checkField("res.branchTaken", res.branchTaken, expRes.branchTaken);
					checkField("res.branchTarget", res.branchTarget, expRes.branchTarget);
					checkField("res.flags", res.flags, expRes.flags);
					checkField("res.illegal", res.illegal, expRes.illegal);
				end
			end
		end
	end

	initial begin
		instrWord ins;
		resultBundle probe;
		int i;
		int waitCycles;
		seed = 32'h96cc400c;
		cycle = 0;
		mismatchErrors = 0;
		otherErrors = 0;
		modelFlags = '0;
		rstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		regA = '0;
		regB = '0;
		pc = '0;
		repeat (10) @(posedge clk);
		#5;
		rstN = 1'b1;

		// Quiet output after reset
		repeat (4) begin
			@(negedge clk);
			checkField("res.valid", res.valid, 0);
		end
		checkField("res.flags", res.flags, 0);

		// Random arithmetic, back to back
		for (i = 0; i < 8; i++) begin
			issue(iType(12'($random(seed)), 5'd2, 5'(i)), randomWord(), randomWord(), 0);
			issue(rType(opAdds, 5'd3, 5'd4, 5'(i)), randomWord(), randomWord(), 0);
			issue(rType(opSubs, 5'd3, 5'd4, 5'(i)), randomWord(), randomWord(), 0);
		end
		// Carry and zero, then signed overflow both ways
		issue(rType(opAdds, 1, 2, 3), '1, 64'd1, 0);
		issue(rType(opAdds, 1, 2, 3), {1'b0, {63{1'b1}}}, 64'd1, 0);
		issue(rType(opSubs, 1, 2, 3), 64'd77, 64'd77, 0);
		issue(rType(opSubs, 1, 2, 3), {1'b1, 63'd0}, 64'd1, 0);
		issue(rType(opSubs, 1, 2, 3), 64'd5, 64'd9, 0);
		idle(2);

		// Addresses with both offset signs
		for (i = 0; i < 6; i++) begin
			issue(dType(opLdur, 9'($random(seed)), 5'd5, 5'd6), randomWord(), 0, 0);
			issue(dType(opStur, 9'($random(seed)), 5'd5, 5'd6), randomWord(), randomWord(), 0);
		end
		issue(dType(opLdur, 9'h100, 5, 6), 64'h1000, 0, 0);
		issue(dType(opStur, 9'h0ff, 5, 6), 64'h1000, 0, 0);

		// Direct branches
		issue(blType(26'($random(seed))), 0, 0, randomWord());
		issue(blType(26'h3ffffff), 0, 0, 64'h400);
		issue(rType(opBr, 0, 5'd7, 0), randomWord(), 0, 64'h800);

		// CBZ, then B.LT right behind the SUBS that decides it
		issue(cbzType(19'd12, 5'd8), 0, 64'd0, 64'h2000);
		issue(cbzType(19'h7fff0, 5'd8), 0, randomWord() | 64'd1, 64'h2000);
		issue(rType(opSubs, 1, 2, 3), 64'd3, 64'd8, 0);
		issue(bltType(19'd5), 0, 0, 64'h3000);
		issue(rType(opSubs, 1, 2, 3), 64'd8, 64'd3, 0);
		issue(bltType(19'h7fffb), 0, 0, 64'h3000);
		issue(rType(opSubs, 1, 2, 3), {1'b1, 63'd0}, 64'd1, 0);
		issue(bltType(19'd1), 0, 0, 64'h3000);

		// Illegal words, B.EQ among them
		issue({opBcond, 19'd4, 1'b0, 4'b0000}, 0, 0, 64'h100);
		i = 0;
		while (i < 10) begin
			ins = $random(seed);
			probe = refResult(ins, 0, 0, 0, modelFlags);
			if (probe.illegal) begin
				issue(ins, randomWord(), randomWord(), randomWord());
				i++;
			end
		end
		idle(1);

		waitCycles = 0;
		while (expQ.size() != 0 && waitCycles < 20) begin
			@(negedge clk);
			waitCycles++;
		end
		if (expQ.size() != 0) begin
			otherErrors++;
			$display("Timed out with %0d results still missing", expQ.size());
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
		if (mismatchErrors + otherErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
legv8Pkg.sv
aluControlUnit.sv
opcodeDecoder.sv
aluExecute.sv
branchResolve.sv
legv8ExecCore.sv
tbLegv8ExecCore.sv
